// File: flist.f
+incdir+.
ldst_pkg.sv
ldst_decode.sv
ldst_pop.sv
ldst_regfile.sv
ldst_control.sv
ldst_unit_top.sv
tb_ldst_unit.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f flist.f --top-module tb_ldst_unit --Mdir obj_dir
	@out=$$(./obj_dir/Vtb_ldst_unit); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb_ldst_unit.sv
`timescale 1ns/1ps
`include "ldst_defs.svh"

module tb_ldst_unit;

	localparam int NROWS = 8;
	localparam int WATCHDOG_NS = (NROWS * 200 + 4) * 10;

	// up to four expected word addresses with the first access in slot 0
	typedef logic [0:3][`LDST_ADDR_W-1:0] addr_seq;

	logic clk, rst_n, issue, core_wr_en, mem_start, mem_write, busy, done;
	ldst_pkg::word instr, core_wr_data, core_rd_value, mem_wdata;
	ldst_pkg::reg_num core_wr_sel, core_rd_sel;
	ldst_pkg::ptr mem_addr;
	logic mem_ready = 1'b0;
	ldst_pkg::word mem_rdata = '0;

	int wait_cnt = 0;
	ldst_pkg::ptr acc_addr;
	ldst_pkg::ptr seen [$];
	bit seen_wr [$];
	ldst_pkg::word mem [ldst_pkg::ptr];

	string row_name [NROWS];
	ldst_pkg::word row_instr [NROWS];
	ldst_pkg::word row_base [NROWS];
	ldst_pkg::word row_fin [NROWS];
	bit row_block [NROWS];
	addr_seq row_addr [NROWS];

	ldst_unit_top dut (.*);

	always #5 clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired before the last instruction finished");
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input ldst_pkg::word expected,
			input ldst_pkg::word actual);
		if (expected !== actual)
			stop_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	endtask

	// untouched words read back a pattern built from their address
	function automatic ldst_pkg::word mem_word(input ldst_pkg::ptr a);
		if (mem.exists(a))
			return mem[a];
		return {a, 2'b00} ^ 32'hC3A5_0F1E;
	endfunction

	// ------------------------------
	// memory model
	// ------------------------------

	always @(negedge clk) begin
		mem_ready = 1'b0;
		if (mem_start && wait_cnt != 0)
			stop_run("mem_start was raised again before the previous mem_ready");
		if (wait_cnt != 0) begin
			wait_cnt--;
			if (wait_cnt == 0) begin
				mem_ready = 1'b1;
				mem_rdata = mem_word(acc_addr);
			end
		end else if (mem_start) begin
			acc_addr = mem_addr;
			seen.push_back(mem_addr);
			seen_wr.push_back(mem_write);
			if (mem_write)
				mem[mem_addr] = mem_wdata;
			wait_cnt = $urandom_range(4, 1);
		end
	end

	task automatic add_row(input int i, input string name, input ldst_pkg::word ins,
			input ldst_pkg::word base, input ldst_pkg::word fin, input bit block,
			input addr_seq addrs);
		row_name[i] = name;
		row_instr[i] = ins;
		row_base[i] = base;
		row_fin[i] = fin;
		row_block[i] = block;
		row_addr[i] = addrs;
	endtask

	task automatic read_reg(input int r, output ldst_pkg::word v);
		@(negedge clk);
		core_rd_sel = ldst_pkg::reg_num'(r);
		#1;
		v = core_rd_value;
	endtask

	task automatic run_row(input int i);
		ldst_pkg::word preset [`LDST_NREGS];
		ldst_pkg::word want [`LDST_NREGS];
		ldst_pkg::word v;
		ldst_pkg::reg_list list;
		int order [$];
		int base;
		int r;
		bit inc;
		bit load;
		base = int'(row_instr[i][19:16]);
		list = row_block[i] ? row_instr[i][`LDST_NREGS-1:0] : '0;
		inc = row_instr[i][23];
		load = row_instr[i][20];
		for (int k = 0; k < `LDST_NREGS; k++) begin
			preset[k] = (k == base) ? row_base[i] : $urandom;
			@(negedge clk);
			core_wr_en = 1'b1;
			core_wr_sel = ldst_pkg::reg_num'(k);
			core_wr_data = preset[k];
		end
		@(negedge clk);
		core_wr_en = 1'b0;
		seen.delete();
		seen_wr.delete();
		instr = row_instr[i];
		issue = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		if (row_block[i]) begin
			while (!done) begin
				check({row_name[i], " busy"}, 32'd1, ldst_pkg::word'(busy));
				@(negedge clk);
			end
		end else begin
			repeat (10) begin
				check({row_name[i], " busy"}, 32'd0, ldst_pkg::word'(busy));
				check({row_name[i], " done"}, 32'd0, ldst_pkg::word'(done));
				@(negedge clk);
			end
		end
		// incrementing takes the lowest register first and decrementing the highest
		for (int k = 0; k < `LDST_NREGS; k++) begin
			r = inc ? k : `LDST_NREGS - 1 - k;
			if (list[r])
				order.push_back(r);
		end
		check({row_name[i], " accesses"}, order.size(), seen.size());
		want = preset;
		for (int k = 0; k < order.size(); k++) begin
			check($sformatf("%s addr %0d", row_name[i], k), ldst_pkg::word'(row_addr[i][k]),
				ldst_pkg::word'(seen[k]));
			check($sformatf("%s write %0d", row_name[i], k), ldst_pkg::word'(!load),
				ldst_pkg::word'(seen_wr[k]));
			if (load)
				want[order[k]] = mem_word(row_addr[i][k]);
			else
				check({row_name[i], " store"}, preset[order[k]], mem_word(row_addr[i][k]));
		end
		want[base] = row_fin[i];
		for (int k = 0; k < `LDST_NREGS; k++) begin
			read_reg(k, v);
			check($sformatf("%s r%0d", row_name[i], k), want[k], v);
		end
	endtask

	// ------------------------------
	// stimulus table and run
	// ------------------------------

	initial begin
		void'($urandom(34));
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		issue = 1'b0;
		core_wr_en = 1'b0;
		core_wr_sel = '0;
		core_wr_data = '0;
		core_rd_sel = '0;
		add_row(0, "stmia_wb", 32'hE8A1_0094, 32'h0000_1000, 32'h0000_100C, 1'b1,
			{30'h400, 30'h401, 30'h402, 30'h0});
		add_row(1, "stmib", 32'hE983_0021, 32'h0000_2000, 32'h0000_2000, 1'b1,
			{30'h801, 30'h802, 30'h0, 30'h0});
		add_row(2, "stmda_wb", 32'hE822_0250, 32'h0000_3000, 32'h0000_2FF4, 1'b1,
			{30'hC00, 30'hBFF, 30'hBFE, 30'h0});
		add_row(3, "stmdb_wb", 32'hE92D_400E, 32'h0000_4000, 32'h0000_3FF0, 1'b1,
			{30'hFFF, 30'hFFE, 30'hFFD, 30'hFFC});
		add_row(4, "ldmia_wb", 32'hE8BD_400E, 32'h0000_3FF0, 32'h0000_4000, 1'b1,
			{30'hFFC, 30'hFFD, 30'hFFE, 30'hFFF});
		add_row(5, "ldmdb", 32'hE915_0101, 32'h0000_5000, 32'h0000_5000, 1'b1,
			{30'h13FF, 30'h13FE, 30'h0, 30'h0});
		add_row(6, "empty_list", 32'hE8A1_0000, 32'h0000_6000, 32'h0000_6000, 1'b1, '0);
		add_row(7, "not_block", 32'hE081_2003, 32'h0000_7000, 32'h0000_7000, 1'b0, '0);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < NROWS; i++)
			run_row(i);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: ldst_unit_top.sv
`timescale 1ns/1ps
`include "ldst_defs.svh"

module ldst_unit_top (
	input  logic             clk,
	input  logic             rst_n,

	input  ldst_pkg::word    instr,
	input  logic             issue,

	input  logic             core_wr_en,
	input  ldst_pkg::reg_num core_wr_sel,
	input  ldst_pkg::word    core_wr_data,
	input  ldst_pkg::reg_num core_rd_sel,
	output ldst_pkg::word    core_rd_value,

	output ldst_pkg::ptr     mem_addr,
	output ldst_pkg::word    mem_wdata,
	output logic             mem_start,
	output logic             mem_write,
	input  logic             mem_ready,
	input  ldst_pkg::word    mem_rdata,

	output logic             busy,
	output logic             done
);

	ldst_pkg::insn_decode dec;
	ldst_pkg::reg_num base_sel, data_sel, seq_wr_sel;
	ldst_pkg::word base_value, data_value, seq_wr_data;
	logic seq_wr_en;

	ldst_decode decode (
		.instr(instr),
		.dec(dec)
	);

	ldst_control control (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.dec(dec),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.base_value(base_value),
		.data_value(data_value),
		.base_sel(base_sel),
		.data_sel(data_sel),
		.seq_wr_en(seq_wr_en),
		.seq_wr_sel(seq_wr_sel),
		.seq_wr_data(seq_wr_data),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_start(mem_start),
		.mem_write(mem_write),
		.busy(busy),
		.done(done)
	);

	ldst_regfile regfile (
		.clk(clk),
		.rst_n(rst_n),
		.core_wr_en(core_wr_en),
		.core_wr_sel(core_wr_sel),
		.core_wr_data(core_wr_data),
		.core_rd_sel(core_rd_sel),
		.core_rd_value(core_rd_value),
		.base_sel(base_sel),
		.base_value(base_value),
		.data_sel(data_sel),
		.data_value(data_value),
		.seq_wr_en(seq_wr_en),
		.seq_wr_sel(seq_wr_sel),
		.seq_wr_data(seq_wr_data)
	);

endmodule

// File: ldst_control.sv
`timescale 1ns/1ps
`include "ldst_defs.svh"

module ldst_control (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 issue,
	input  ldst_pkg::insn_decode dec,

	input  logic                 mem_ready,
	input  ldst_pkg::word        mem_rdata,

	input  ldst_pkg::word        base_value,
	input  ldst_pkg::word        data_value,
	output ldst_pkg::reg_num     base_sel,
	output ldst_pkg::reg_num     data_sel,

	output logic                 seq_wr_en,
	output ldst_pkg::reg_num     seq_wr_sel,
	output ldst_pkg::word        seq_wr_data,

	output ldst_pkg::ptr         mem_addr,
	output ldst_pkg::word        mem_wdata,
	output logic                 mem_start,
	output logic                 mem_write,

	output logic                 busy,
	output logic                 done
);

	localparam int PAD_W = `LDST_WORD_W - `LDST_ADDR_W;

	ldst_pkg::ctrl_cycle state, next_state;
	logic load_q, inc_q, pre_q, wb_q;
	logic accept, beat_done;
	ldst_pkg::reg_num base_q;
	ldst_pkg::reg_list pending, remaining;
	ldst_pkg::ptr cur_q, step;

	logic pop_valid;
	ldst_pkg::reg_num pop_lower, pop_upper, popped;
	ldst_pkg::reg_list next_lower, next_upper;

	ldst_pop pop (
		.regs(pending),
		.valid(pop_valid),
		.pop_lower(pop_lower),
		.pop_upper(pop_upper),
		.next_lower(next_lower),
		.next_upper(next_upper)
	);

	// incrementing walks up from the lowest register, decrementing down from the highest
	assign popped = inc_q ? pop_lower : pop_upper;
	assign remaining = inc_q ? next_lower : next_upper;

	assign accept = issue && dec.is_block && state == ldst_pkg::IDLE;
	assign beat_done = state == ldst_pkg::WAIT && mem_ready;

	// cur_q is the running base, after the last beat it is already b plus or minus n
	assign step = inc_q ? cur_q + ptr_one() : cur_q - ptr_one();

	function automatic ldst_pkg::ptr ptr_one();
		return ldst_pkg::ptr'(1);
	endfunction

	// ------------------------------
	// sequencer
	// ------------------------------

	always_comb begin
		next_state = state;
		unique case (state)
			ldst_pkg::IDLE:
				if (accept)
					next_state = ldst_pkg::TRANSFER;
			ldst_pkg::TRANSFER:
				if (pop_valid)
					next_state = ldst_pkg::WAIT;
				else
					next_state = wb_q ? ldst_pkg::WRITEBACK : ldst_pkg::IDLE;
			ldst_pkg::WAIT:
				if (mem_ready) begin
					if (|remaining)
						next_state = ldst_pkg::TRANSFER;
					else
						next_state = wb_q ? ldst_pkg::WRITEBACK : ldst_pkg::IDLE;
				end
			ldst_pkg::WRITEBACK:
				next_state = ldst_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ldst_pkg::IDLE;
			done <= 1'b0;
			pending <= '0;
			load_q <= 1'b0;
			inc_q <= 1'b0;
			pre_q <= 1'b0;
			wb_q <= 1'b0;
		end else begin
			state <= next_state;
			done <= state != ldst_pkg::IDLE && next_state == ldst_pkg::IDLE;
			if (accept) begin
				pending <= dec.regs;
				load_q <= dec.load;
				inc_q <= dec.increment;
				pre_q <= dec.pre_indexed;
				wb_q <= dec.writeback;
			end else if (beat_done) begin
				pending <= remaining;
			end
		end
	end

	// base register and running address
	always_ff @(posedge clk) begin
		if (accept) begin
			base_q <= dec.base;
			cur_q <= base_value[`LDST_WORD_W-1 -: `LDST_ADDR_W];
		end else if (beat_done) begin
			cur_q <= step;
		end
	end

	// ------------------------------
	// memory port and register writes
	// ------------------------------

	// pending, cur_q and the modes only move on mem_ready, so the port holds
	assign mem_start = state == ldst_pkg::TRANSFER && pop_valid;
	assign mem_write = (state == ldst_pkg::TRANSFER || state == ldst_pkg::WAIT) && !load_q;
	assign mem_addr = pre_q ? step : cur_q;
	assign mem_wdata = data_value;

	assign base_sel = dec.base;
	assign data_sel = popped;
	assign busy = state != ldst_pkg::IDLE;

	always_comb begin
		seq_wr_en = 1'b0;
		seq_wr_sel = popped;
		seq_wr_data = mem_rdata;
		if (beat_done && load_q) begin
			seq_wr_en = 1'b1;
		end else if (state == ldst_pkg::WRITEBACK) begin
			seq_wr_en = 1'b1;
			seq_wr_sel = base_q;
			seq_wr_data = {cur_q, {PAD_W{1'b0}}};
		end
	end

endmodule

// File: ldst_regfile.sv
`timescale 1ns/1ps
`include "ldst_defs.svh"

module ldst_regfile (
	input  logic              clk,
	input  logic              rst_n,

	input  logic              core_wr_en,
	input  ldst_pkg::reg_num  core_wr_sel,
	input  ldst_pkg::word     core_wr_data,
	input  ldst_pkg::reg_num  core_rd_sel,
	output ldst_pkg::word     core_rd_value,

	input  ldst_pkg::reg_num  base_sel,
	output ldst_pkg::word     base_value,
	input  ldst_pkg::reg_num  data_sel,
	output ldst_pkg::word     data_value,

	input  logic              seq_wr_en,
	input  ldst_pkg::reg_num  seq_wr_sel,
	input  ldst_pkg::word     seq_wr_data
);

	ldst_pkg::word regs [`LDST_NREGS];

	// ------------------------------
	// write ports
	// ------------------------------

	// the sequencer owns the file while a transfer runs, so its write
	// takes the slot when both ports fire together
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LDST_NREGS; i++)
				regs[i] <= '0;
		end else if (seq_wr_en) begin
			regs[seq_wr_sel] <= seq_wr_data;
		end else if (core_wr_en) begin
			regs[core_wr_sel] <= core_wr_data;
		end
	end

	// ------------------------------
	// read ports
	// ------------------------------

	assign core_rd_value = regs[core_rd_sel];
	assign base_value = regs[base_sel];
	assign data_value = regs[data_sel];

endmodule

// File: ldst_pop.sv
`timescale 1ns/1ps
`include "ldst_defs.svh"

module ldst_pop (
	input  ldst_pkg::reg_list regs,
	output logic              valid,
	output ldst_pkg::reg_num  pop_lower,
	output ldst_pkg::reg_num  pop_upper,
	output ldst_pkg::reg_list next_lower,
	output ldst_pkg::reg_list next_upper
);

	assign valid = |regs;

	// ------------------------------
	// priority search, both ends
	// ------------------------------

	// scanning downward leaves the lowest set bit as the last hit
	always_comb begin
		pop_lower = '0;
		for (int i = `LDST_NREGS - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = ldst_pkg::reg_num'(i);
		end
	end

	// and scanning upward leaves the highest
	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < `LDST_NREGS; i++) begin
			if (regs[i])
				pop_upper = ldst_pkg::reg_num'(i);
		end
	end

	// an empty list stays empty because the cleared bit was already zero
	always_comb begin
		next_lower = regs;
		next_upper = regs;
		next_lower[pop_lower] = 1'b0;
		next_upper[pop_upper] = 1'b0;
	end

endmodule

// File: ldst_decode.sv
`timescale 1ns/1ps
`include "ldst_defs.svh"

module ldst_decode (
	input  ldst_pkg::word        instr,
	output ldst_pkg::insn_decode dec
);

	// block transfers sit in the 100 group of bits 27 to 25
	localparam logic [2:0] BLOCK_GROUP = 3'b100;

	logic p_bit;
	logic u_bit;
	logic w_bit;
	logic l_bit;

	// bit 22 (user bank) is not decoded here
	assign p_bit = instr[24];
	assign u_bit = instr[23];
	assign w_bit = instr[21];
	assign l_bit = instr[20];

	always_comb begin
		dec.is_block = instr[27:25] == BLOCK_GROUP;
		dec.load = l_bit;
		dec.increment = u_bit;
		dec.pre_indexed = p_bit;
		dec.writeback = w_bit;
		dec.base = instr[19:16];
		dec.regs = instr[`LDST_NREGS-1:0];
	end

endmodule

// File: ldst_pkg.sv
`include "ldst_defs.svh"

package ldst_pkg;

	// ------------------------------
	// plain vector types
	// ------------------------------

	typedef logic [`LDST_WORD_W-1:0] word;
	typedef logic [`LDST_ADDR_W-1:0] ptr;
	typedef logic [$clog2(`LDST_NREGS)-1:0] reg_num;
	typedef logic [`LDST_NREGS-1:0] reg_list;

	// ------------------------------
	// decoded block transfer
	// ------------------------------

	typedef struct packed {
		logic    is_block;
		logic    load;
		logic    increment;
		logic    pre_indexed;
		logic    writeback;
		reg_num  base;
		reg_list regs;
	} insn_decode;

	// sequencer states
	typedef enum logic [1:0] {
		IDLE,
		TRANSFER,
		WAIT,
		WRITEBACK
	} ctrl_cycle;

endpackage

// File: ldst_defs.svh
`ifndef LDST_DEFS_SVH
`define LDST_DEFS_SVH

// ------------------------------
// datapath widths
// ------------------------------

// width of a register and of a memory word
`define LDST_WORD_W 32

// architectural registers visible to a block transfer
`define LDST_NREGS 16

// word address, byte address bits 31 down to 2
`define LDST_ADDR_W 30

`endif
